// File: hdl/lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Byte address width.
`define LSU_ADDR_W 32

// Bytes per memory line.
`define LSU_LINE_BYTES 16

// Byte offset within a line.
`define LSU_OFS_W 4

// Bytes per register word.
`define LSU_WORD_BYTES 4

// Register file size and index width.
`define LSU_GPR_CNT 16
`define LSU_GPR_IDX_W 4

// Width of a queued instruction.
`define LSU_INSTR_W 48

`endif

// File: hdl/lsu_pkg.sv
`default_nettype none

`include "lsu_defs.svh"

package lsu_pkg;

    // Opcodes in instruction bits 7 to 3.
    typedef enum logic [4:0] {
        LOD_KA = 5'b00000,
        LOD_AB = 5'b11001,
        STR_AK = 5'b10000,
        STR_AB = 5'b01001
    } lsu_op_e;

    // One register value.
    typedef logic [`LSU_WORD_BYTES*8-1:0] word_t;

    // Line index, the byte address without its offset bits.
    typedef logic [`LSU_ADDR_W-`LSU_OFS_W-1:0] line_addr_t;
    typedef logic [`LSU_OFS_W-1:0] line_ofs_t;

    // Line payload and its byte enables.
    typedef logic [`LSU_LINE_BYTES*8-1:0] line_dat_t;
    typedef logic [`LSU_LINE_BYTES-1:0] line_msk_t;

    typedef logic [`LSU_GPR_IDX_W-1:0] gpr_idx_t;
    typedef logic [`LSU_INSTR_W-1:0] instr_t;

endpackage

`default_nettype wire

// File: hdl/lsu_access_planner.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_access_planner import lsu_pkg::*; (
    input  wire instr_t     instr,
    input  wire word_t      gpr_oup [`LSU_GPR_CNT],
    output logic            is_load,
    output logic            is_store,
    output logic            is_valid,
    output line_addr_t      lo_line,
    output line_addr_t      hi_line,
    output line_ofs_t       ofs,
    output logic            split,
    output gpr_idx_t        dst_idx,
    output word_t           st_word
);

    lsu_op_e                op;
    gpr_idx_t               fld_a;
    gpr_idx_t               fld_b;
    logic [`LSU_ADDR_W-1:0] imm;
    logic [`LSU_ADDR_W-1:0] ea;
    logic [`LSU_ADDR_W-1:0] last;

    // Instruction fields.
    assign op    = lsu_op_e'(instr[7:3]);
    assign fld_a = instr[11:8];
    assign fld_b = instr[15:12];
    assign imm   = instr[47:16];

    // Address source and destination per opcode.
    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        ea       = imm;
        dst_idx  = fld_a;
        case (op)
            LOD_KA: begin
                is_load = 1'b1;
            end
            LOD_AB: begin
                // Address in A, result goes to B.
                is_load = 1'b1;
                ea      = gpr_oup[fld_a];
                dst_idx = fld_b;
            end
            STR_AK: begin
                is_store = 1'b1;
            end
            STR_AB: begin
                is_store = 1'b1;
                ea       = gpr_oup[fld_b];
            end
            default: begin
                // Unknown opcode, no access.
                is_load  = 1'b0;
            end
        endcase
    end

    assign is_valid = is_load || is_store;

    // Stores always take their data from register A.
    assign st_word = gpr_oup[fld_a];

    // Last byte of the word decides whether a second line is needed.
    assign last    = ea + `LSU_ADDR_W'(`LSU_WORD_BYTES - 1);
    assign lo_line = ea[`LSU_ADDR_W-1:`LSU_OFS_W];
    assign hi_line = last[`LSU_ADDR_W-1:`LSU_OFS_W];
    assign ofs     = ea[`LSU_OFS_W-1:0];
    assign split   = lo_line != hi_line;

endmodule

`default_nettype wire

// File: hdl/lsu_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_sequencer import lsu_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       en,
    input  wire logic       is_load,
    input  wire logic       is_store,
    input  wire logic       is_valid,
    input  wire logic       split,
    input  wire line_addr_t lo_line,
    input  wire line_addr_t hi_line,
    input  wire logic       mem_req_rdy,
    input  wire logic       mem_rsp_vld,
    input  wire line_addr_t mem_rsp_addr,
    output logic            dn,
    output logic            mem_req_vld,
    output line_addr_t      mem_req_addr,
    output logic            mem_req_wr,
    output logic            mem_rsp_rdy,
    output logic            part,
    output logic            capture,
    output logic            wr_stb
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_REQ_LO,
        ST_RSP_LO,
        ST_REQ_HI,
        ST_RSP_HI,
        ST_DONE
    } seq_state_e;

    seq_state_e state_q;
    seq_state_e state_d;
    logic       req_xfer;
    logic       rsp_hit;

    // Upper line states.
    assign part = (state_q == ST_REQ_HI) || (state_q == ST_RSP_HI);

    // Request side, fields follow the active part.
    assign mem_req_vld  = (state_q == ST_REQ_LO) || (state_q == ST_REQ_HI);
    assign mem_req_addr = part ? hi_line : lo_line;
    assign mem_req_wr   = is_store;
    assign req_xfer     = mem_req_vld && mem_req_rdy;

    // Reply side.
    assign mem_rsp_rdy = (state_q == ST_RSP_LO) || (state_q == ST_RSP_HI);
    // A reply for another line is consumed and dropped.
    assign rsp_hit = mem_rsp_vld && mem_rsp_rdy && (mem_rsp_addr == mem_req_addr);

    assign capture = rsp_hit;
    assign dn      = state_q == ST_DONE;
    assign wr_stb  = (state_q == ST_DONE) && is_load;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                // Unknown opcodes go straight to done.
                if (en) begin
                    state_d = is_valid ? ST_REQ_LO : ST_DONE;
                end
            end
            ST_REQ_LO: begin
                if (req_xfer) begin
                    if (is_load) begin
                        state_d = ST_RSP_LO;
                    end else begin
                        // Store is complete at transfer.
                        state_d = split ? ST_REQ_HI : ST_DONE;
                    end
                end
            end
            ST_RSP_LO: begin
                if (rsp_hit) begin
                    state_d = split ? ST_REQ_HI : ST_DONE;
                end
            end
            ST_REQ_HI: begin
                if (req_xfer) begin
                    state_d = is_load ? ST_RSP_HI : ST_DONE;
                end
            end
            ST_RSP_HI: begin
                if (rsp_hit) begin
                    state_d = ST_DONE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
        // Core dropped en, abandon the instruction.
        if (!en) begin
            state_d = ST_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Held request keeps its line and direction while the core holds the instruction.
    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req_vld && !mem_req_rdy && en
        |=> mem_req_vld && $stable(mem_req_addr) && $stable(mem_req_wr))
        else $error("request changed before acceptance");

    // Done is a single cycle pulse.
    a_dn_pulse: assert property (@(posedge clk) disable iff (rst) dn |=> !dn)
        else $error("dn held for two cycles");

endmodule

`default_nettype wire

// File: hdl/lsu_load_gather.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_load_gather import lsu_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       capture,
    input  wire logic       part,
    input  wire line_ofs_t  ofs,
    input  wire logic       wr_stb,
    input  wire gpr_idx_t   dst_idx,
    input  wire line_dat_t  mem_rsp_dat,
    output logic            gpr_wr_en,
    output gpr_idx_t        gpr_wr_idx,
    output word_t           gpr_wr_dat
);

    word_t word_q;
    logic  word_vld;

    // Byte i of the word sits at line position ofs + i.
    // Bit 4 of that position says which line holds it.
    for (genvar i = 0; i < `LSU_WORD_BYTES; i++) begin : g_byte
        logic [`LSU_OFS_W:0] pos;

        assign pos = {1'b0, ofs} + (`LSU_OFS_W + 1)'(i);

        always_ff @(posedge clk) begin
            if (capture && (pos[`LSU_OFS_W] == part)) begin
                word_q[i*8 +: 8] <= mem_rsp_dat[pos[`LSU_OFS_W-1:0]*8 +: 8];
            end
        end
    end

    // Set once any reply has landed, cleared by the write.
    always_ff @(posedge clk) begin
        if (rst) begin
            word_vld <= 1'b0;
        end else if (capture) begin
            word_vld <= 1'b1;
        end else if (wr_stb) begin
            word_vld <= 1'b0;
        end
    end

    // Register write port.
    assign gpr_wr_en  = wr_stb && word_vld;
    assign gpr_wr_idx = dst_idx;
    assign gpr_wr_dat = word_q;

    // Write must see the word of the last capture.
    a_cap_wr_excl: assert property (@(posedge clk) disable iff (rst) !(capture && wr_stb))
        else $error("capture and write in the same cycle");

endmodule

`default_nettype wire

// File: hdl/lsu_store_lanes.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_store_lanes import lsu_pkg::*; (
    input  wire logic       part,
    input  wire logic       split,
    input  wire line_ofs_t  ofs,
    input  wire word_t      st_word,
    output line_msk_t       mem_req_msk,
    output line_dat_t       mem_req_dat
);

    // Each lane works out which word byte lands on it.
    // Upper part lanes are counted from the start of the lower line.
    for (genvar j = 0; j < `LSU_LINE_BYTES; j++) begin : g_lane
        logic [`LSU_OFS_W:0] pos;
        logic                lane_on;

        // Underflow wraps high and drops out of range.
        assign pos = {part, `LSU_OFS_W'(j)} - {1'b0, ofs};

        // Upper line only carries bytes on a split store.
        assign lane_on = (pos < (`LSU_OFS_W + 1)'(`LSU_WORD_BYTES)) && (!part || split);

        assign mem_req_msk[j] = lane_on;
        // Unused lanes are driven as zero.
        assign mem_req_dat[j*8 +: 8] = lane_on ? st_word[pos[1:0]*8 +: 8] : 8'h00;
    end

endmodule

`default_nettype wire

// File: hdl/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_top import lsu_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    // Core side.
    input  wire logic       en,
    input  wire instr_t     instr,
    input  wire word_t      gpr_oup [`LSU_GPR_CNT],
    output logic            dn,
    output logic            gpr_wr_en,
    output gpr_idx_t        gpr_wr_idx,
    output word_t           gpr_wr_dat,
    // Memory requests.
    output logic            mem_req_vld,
    output line_addr_t      mem_req_addr,
    output logic            mem_req_wr,
    output line_msk_t       mem_req_msk,
    output line_dat_t       mem_req_dat,
    input  wire logic       mem_req_rdy,
    // Memory replies.
    input  wire logic       mem_rsp_vld,
    input  wire line_addr_t mem_rsp_addr,
    input  wire line_dat_t  mem_rsp_dat,
    output logic            mem_rsp_rdy
);

    logic       is_load;
    logic       is_store;
    logic       is_valid;
    logic       split;
    logic       part;
    logic       capture;
    logic       wr_stb;
    line_addr_t lo_line;
    line_addr_t hi_line;
    line_ofs_t  ofs;
    gpr_idx_t   dst_idx;
    word_t      st_word;

    // Decode of the held instruction.
    lsu_access_planner u_planner (
        .instr    (instr),
        .gpr_oup  (gpr_oup),
        .is_load  (is_load),
        .is_store (is_store),
        .is_valid (is_valid),
        .lo_line  (lo_line),
        .hi_line  (hi_line),
        .ofs      (ofs),
        .split    (split),
        .dst_idx  (dst_idx),
        .st_word  (st_word)
    );

    // Line transaction FSM.
    lsu_sequencer u_seq (
        .clk          (clk),
        .rst          (rst),
        .en           (en),
        .is_load      (is_load),
        .is_store     (is_store),
        .is_valid     (is_valid),
        .split        (split),
        .lo_line      (lo_line),
        .hi_line      (hi_line),
        .mem_req_rdy  (mem_req_rdy),
        .mem_rsp_vld  (mem_rsp_vld),
        .mem_rsp_addr (mem_rsp_addr),
        .dn           (dn),
        .mem_req_vld  (mem_req_vld),
        .mem_req_addr (mem_req_addr),
        .mem_req_wr   (mem_req_wr),
        .mem_rsp_rdy  (mem_rsp_rdy),
        .part         (part),
        .capture      (capture),
        .wr_stb       (wr_stb)
    );

    lsu_load_gather u_gather (
        .clk         (clk),
        .rst         (rst),
        .capture     (capture),
        .part        (part),
        .ofs         (ofs),
        .wr_stb      (wr_stb),
        .dst_idx     (dst_idx),
        .mem_rsp_dat (mem_rsp_dat),
        .gpr_wr_en   (gpr_wr_en),
        .gpr_wr_idx  (gpr_wr_idx),
        .gpr_wr_dat  (gpr_wr_dat)
    );

    lsu_store_lanes u_lanes (
        .part        (part),
        .split       (split),
        .ofs         (ofs),
        .st_word     (st_word),
        .mem_req_msk (mem_req_msk),
        .mem_req_dat (mem_req_dat)
    );

endmodule

`default_nettype wire

// File: verif/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_tb import lsu_pkg::*; ();

    localparam int N_OPS    = 60;
    localparam int MEM_SIZE = 4096;

    logic       clk;
    logic       rst;
    logic       en;
    instr_t     instr;
    word_t      regs [`LSU_GPR_CNT];
    logic       dn;
    logic       gpr_wr_en;
    gpr_idx_t   gpr_wr_idx;
    word_t      gpr_wr_dat;
    logic       mem_req_vld;
    line_addr_t mem_req_addr;
    logic       mem_req_wr;
    line_msk_t  mem_req_msk;
    line_dat_t  mem_req_dat;
    logic       mem_req_rdy;
    logic       mem_rsp_vld;
    line_addr_t mem_rsp_addr;
    line_dat_t  mem_rsp_dat;
    logic       mem_rsp_rdy;

    // Byte memory model and the state of the running operation.
    logic [7:0]  mem [MEM_SIZE];
    int          req_cnt;
    line_addr_t  req_lines [$];
    int          cur_ea;
    word_t       cur_word;
    logic        stray;
    string       cur_name;

    lsu_top UUT (
        .clk(clk), .rst(rst), .en(en), .instr(instr), .gpr_oup(regs),
        .dn(dn), .gpr_wr_en(gpr_wr_en), .gpr_wr_idx(gpr_wr_idx), .gpr_wr_dat(gpr_wr_dat),
        .mem_req_vld(mem_req_vld), .mem_req_addr(mem_req_addr), .mem_req_wr(mem_req_wr),
        .mem_req_msk(mem_req_msk), .mem_req_dat(mem_req_dat), .mem_req_rdy(mem_req_rdy),
        .mem_rsp_vld(mem_rsp_vld), .mem_rsp_addr(mem_rsp_addr), .mem_rsp_dat(mem_rsp_dat),
        .mem_rsp_rdy(mem_rsp_rdy)
    );

    always #20 clk = ~clk;

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act)
        else report_fail($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    endtask

    // Little-endian word at a byte address of the memory model.
    function automatic word_t ref_load(input int ea);
        word_t w;
        for (int k = 0; k < `LSU_WORD_BYTES; k++) begin
            w[k*8 +: 8] = mem[ea + k];
        end
        return w;
    endfunction

    // Memory byte after a store of w at ea.
    function automatic logic [7:0] ref_store_byte(input int addr, input int ea,
                                                  input word_t w, input logic [7:0] old);
        if (addr >= ea && addr < ea + `LSU_WORD_BYTES) begin
            return w[(addr - ea)*8 +: 8];
        end
        return old;
    endfunction

    // Writes must only happen together with dn.
    always @(negedge clk) begin
        if (!rst && gpr_wr_en) begin
            assert (dn) else report_fail("register write without dn");
        end
    end

    // Memory model, answers one request at a time.
    initial begin : mem_server
        line_addr_t s_addr;
        logic       s_wr;
        line_msk_t  s_msk;
        line_dat_t  s_dat;
        int         delay;
        int         addr;
        logic       in_rng;
        mem_req_rdy  = 1'b0;
        mem_rsp_vld  = 1'b0;
        mem_rsp_addr = '0;
        mem_rsp_dat  = '0;
        forever begin
            @(negedge clk);
            if (!rst && mem_req_vld) begin
                s_addr = mem_req_addr;
                s_wr   = mem_req_wr;
                s_msk  = mem_req_msk;
                s_dat  = mem_req_dat;
                req_cnt++;
                req_lines.push_back(s_addr);
                assert (s_addr < MEM_SIZE / 16) else report_fail("request outside the memory");
                delay = $urandom_range(0, 3);
                repeat (delay) begin
                    @(negedge clk);
                    assert (mem_req_vld && mem_req_addr == s_addr && mem_req_wr == s_wr
                            && mem_req_msk == s_msk && mem_req_dat == s_dat)
                    else report_fail("request changed while waiting for rdy");
                end
                if (s_wr) begin
                    // Mask covers exactly the bytes of the word in this line.
                    for (int j = 0; j < 16; j++) begin
                        addr   = int'(s_addr) * 16 + j;
                        in_rng = addr >= cur_ea && addr < cur_ea + 4;
                        check_val({cur_name, " mask"}, 32'(in_rng), 32'(s_msk[j]));
                        check_val({cur_name, " lane"},
                                  in_rng ? 32'(cur_word[(addr - cur_ea)*8 +: 8]) : 32'h0,
                                  32'(s_dat[j*8 +: 8]));
                    end
                    // The held request transfers at the coming edge, so the line is written now.
                    for (int j = 0; j < 16; j++) begin
                        if (s_msk[j]) mem[int'(s_addr) * 16 + j] = s_dat[j*8 +: 8];
                    end
                end
                mem_req_rdy = 1'b1;
                @(negedge clk);
                mem_req_rdy = 1'b0;
                if (!s_wr) begin
                    repeat ($urandom_range(0, 3)) @(negedge clk);
                    if (stray) begin
                        // Reply for a line nobody asked for.
                        mem_rsp_vld  = 1'b1;
                        mem_rsp_addr = s_addr ^ line_addr_t'(28'h80);
                        mem_rsp_dat  = {$urandom, $urandom, $urandom, $urandom};
                        @(negedge clk);
                    end
                    mem_rsp_vld  = 1'b1;
                    mem_rsp_addr = s_addr;
                    for (int j = 0; j < 16; j++) begin
                        mem_rsp_dat[j*8 +: 8] = mem[int'(s_addr) * 16 + j];
                    end
                    @(negedge clk);
                    mem_rsp_vld = 1'b0;
                end
            end
        end
    end

    // One instruction from en to dn, then the checks.
    task automatic run_op(input string name, input logic [4:0] op, input int a, input int b,
                          input int imm, input int ea);
        logic        ld;
        logic        st;
        int          dst;
        int          exp_reqs;
        int          wr_cnt;
        word_t       got;
        gpr_idx_t    got_idx;
        word_t       exp_w;
        logic [7:0]  old [32];
        int          base;
        ld       = (op == LOD_KA) || (op == LOD_AB);
        st       = (op == STR_AK) || (op == STR_AB);
        dst      = (op == LOD_AB) ? b : a;
        exp_reqs = (ld || st) ? (((ea % 16) > 12) ? 2 : 1) : 0;
        base     = (ea / 16) * 16;
        exp_w    = ref_load(ea);
        for (int k = 0; k < 32; k++) old[k] = mem[base + k];
        cur_name = name;
        cur_ea   = ea;
        cur_word = regs[a];
        req_cnt  = 0;
        req_lines.delete();
        wr_cnt   = 0;
        @(negedge clk);
        instr = {imm[31:0], 4'(b), 4'(a), op, 3'b000};
        en    = 1'b1;
        forever begin
            @(negedge clk);
            if (gpr_wr_en) begin
                wr_cnt++;
                got     = gpr_wr_dat;
                got_idx = gpr_wr_idx;
            end
            if (dn) break;
        end
        en = 1'b0;
        check_val({name, " requests"}, exp_reqs, req_cnt);
        if (exp_reqs > 0) check_val({name, " lower line"}, ea / 16, 32'(req_lines[0]));
        if (exp_reqs > 1) check_val({name, " upper line"}, ea / 16 + 1, 32'(req_lines[1]));
        check_val({name, " writes"}, ld ? 1 : 0, wr_cnt);
        if (ld) begin
            check_val({name, " index"}, dst, 32'(got_idx));
            check_val({name, " word"}, exp_w, got);
            regs[dst] = got;
        end
        for (int k = 0; k < 32; k++) begin
            check_val({name, " memory"}, st ? ref_store_byte(base + k, ea, cur_word, old[k])
                      : old[k], mem[base + k]);
        end
    endtask

    initial begin : watchdog
        #((N_OPS * 40 + 10) * 40);
        report_fail("timeout, the unit stopped answering");
    end

    initial begin : stimulus
        int kind;
        int ea;
        int a;
        int b;
        void'($urandom(64504));
        clk   = 1'b0;
        rst   = 1'b1;
        en    = 1'b0;
        instr = '0;
        stray = 1'b0;
        for (int i = 0; i < MEM_SIZE; i++) mem[i] = 8'($urandom);
        for (int i = 0; i < `LSU_GPR_CNT; i++) regs[i] = $urandom;
        // Outputs stay quiet through reset and one cycle after.
        repeat (5) begin
            @(negedge clk);
            assert (!dn && !gpr_wr_en && !mem_req_vld && !mem_rsp_rdy)
            else report_fail("outputs active during reset");
        end
        rst = 1'b0;
        @(negedge clk);
        assert (!dn && !gpr_wr_en && !mem_req_vld && !mem_rsp_rdy)
        else report_fail("outputs active after reset");
        for (int i = 0; i < N_OPS; i++) begin
            kind = i % 6;
            ea   = $urandom_range(0, 254) * 16;
            ea   += (kind < 2) ? $urandom_range(0, 12)
                  : (kind == 2) ? $urandom_range(13, 15) : $urandom_range(0, 15);
            a    = $urandom_range(0, 15);
            b    = $urandom_range(0, 15);
            stray = (kind < 3) && ($urandom_range(0, 2) == 0);
            case (kind)
                0: run_op("lod_ka", LOD_KA, a, b, ea, ea);
                1: begin
                    regs[a] = ea;
                    run_op("lod_ab", LOD_AB, a, b, $urandom, ea);
                end
                2: begin
                    if (i % 12 == 2) begin
                        run_op("lod_ka_split", LOD_KA, a, b, ea, ea);
                    end else begin
                        regs[a] = ea;
                        run_op("lod_ab_split", LOD_AB, a, b, $urandom, ea);
                    end
                end
                3: begin
                    regs[a] = $urandom;
                    run_op("str_ak", STR_AK, a, b, ea, ea);
                end
                4: begin
                    if (a == b) b = a ^ 1;
                    regs[a] = $urandom;
                    regs[b] = ea;
                    run_op("str_ab", STR_AB, a, b, $urandom, ea);
                end
                default: run_op("unknown_op", 5'b00001, a, b, ea, ea);
            endcase
        end
        @(negedge clk);
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_access_planner.sv
hdl/lsu_sequencer.sv
hdl/lsu_load_gather.sv
hdl/lsu_store_lanes.sv
hdl/lsu_top.sv
verif/lsu_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module lsu_tb -f verilog.f \
    -o lsu_sim > sim.log 2>&1 && ./obj_dir/lsu_sim >> sim.log 2>&1 || true
grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
